/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= mem_tb
RTL_TOP   ?= mem_top
FILELIST  ?= list.f
OBJDIR    ?= obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* common/mem_pkg.sv */
package mem_pkg;

  // access kinds as carried on req_kind
  // instruction fetch
  localparam logic [1:0] kind_instr = 2'd0;
  // data load
  localparam logic [1:0] kind_data = 2'd1;
  // data store
  localparam logic [1:0] kind_write = 2'd2;
  // code 3 is not a legal kind and always faults

  // access sizes as carried on req_size
  // one byte
  localparam logic [1:0] size_byte = 2'd0;
  // two bytes
  localparam logic [1:0] size_half = 2'd1;
  // four bytes
  localparam logic [1:0] size_word = 2'd2;
  // code 3 is not a legal size and always faults

  // bus widths
  localparam int addr_w = 32;
  localparam int data_w = 32;

  // storage depth in words, 1 KiB total
  // addresses wrap on this depth once the region check has passed
  localparam int mem_words = 256;

  // request buffer slots
  // also the credit count the cpu starts with
  localparam int queue_depth = 4;

  // protection regions and the index width for cfg_sel
  localparam int num_regions = 2;
  localparam int region_idx_w = 1;

  // permission bits per region
  // bit 0 read, bit 1 write, bit 2 execute
  localparam int perm_w = 3;

  // one storage word
  // seen as a whole or as four byte lanes, lane 0 least significant
  typedef union packed {
    logic [data_w-1:0]        word;
    logic [data_w/8-1:0][7:0] bytes;
  } mem_word_u;

endpackage

/* list.f */
+incdir+verif
common/mem_pkg.sv
mmu/mmu_region_cfg.sv
mmu/mmu_access_check.sv
source/req_credit_queue.sv
source/mem_array.sv
source/mem_top.sv
verif/mem_tb.sv

/* mmu/mmu_access_check.sv */
`timescale 1ns/1ps

module mmu_access_check
  import mem_pkg::*;
(
  input  logic                               head_valid,
  input  logic [1:0]                         head_kind,
  input  logic [1:0]                         head_size,
  input  logic [addr_w-1:0]                  head_addr,
  input  logic [num_regions-1:0][addr_w-1:0] region_base,
  input  logic [num_regions-1:0][addr_w-1:0] region_limit,
  input  logic [num_regions-1:0][perm_w-1:0] region_perm,
  output logic                               access_ok
);

  logic              code_ok;
  logic              aligned;
  logic [2:0]        num_bytes;
  // one extra bit so an access past the top of the space cannot wrap
  logic [addr_w:0]   last_addr;
  logic              hit;
  logic [perm_w-1:0] hit_perm;
  logic              perm_ok;

  // only the three defined codes of each field are legal
  assign code_ok = ((head_kind == kind_instr) || (head_kind == kind_data) ||
                    (head_kind == kind_write)) &&
                   ((head_size == size_byte) || (head_size == size_half) ||
                    (head_size == size_word));

  // byte count and natural alignment per size
  always_comb begin
    case (head_size)
      size_byte: begin
        num_bytes = 3'd1;
        aligned   = 1'b1;
      end
      size_half: begin
        num_bytes = 3'd2;
        aligned   = (head_addr[0] == 1'b0);
      end
      size_word: begin
        num_bytes = 3'd4;
        aligned   = (head_addr[1:0] == 2'b00);
      end
      default: begin
        num_bytes = 3'd0;
        aligned   = 1'b0;
      end
    endcase
  end

  // last byte touched
  assign last_addr = {1'b0, head_addr} + (addr_w + 1)'(num_bytes) - 1'b1;

  // first region holding the whole access wins
  always_comb begin
    hit      = 1'b0;
    hit_perm = '0;
    for (int i = 0; i < num_regions; i++) begin
      if (!hit && (head_addr >= region_base[i]) &&
          (last_addr <= {1'b0, region_limit[i]})) begin
        hit      = 1'b1;
        hit_perm = region_perm[i];
      end
    end
  end

  // fetch needs execute, load needs read, store needs write
  always_comb begin
    case (head_kind)
      kind_instr: perm_ok = hit_perm[2];
      kind_data:  perm_ok = hit_perm[0];
      kind_write: perm_ok = hit_perm[1];
      default:    perm_ok = 1'b0;
    endcase
  end

  assign access_ok = head_valid && code_ok && aligned && hit && perm_ok;

  // the cpu side is expected to send only defined codes
  always_comb begin
    if (head_valid) begin
      assert (code_ok)
        else $error("mmu_access_check: illegal kind %0d or size %0d at head",
                    head_kind, head_size);
    end
  end

endmodule

/* mmu/mmu_region_cfg.sv */
`timescale 1ns/1ps

module mmu_region_cfg
  import mem_pkg::*;
(
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               cfg_we,
  input  logic [region_idx_w-1:0]            cfg_sel,
  input  logic [addr_w-1:0]                  cfg_base,
  input  logic [addr_w-1:0]                  cfg_limit,
  input  logic [perm_w-1:0]                  cfg_perm,
  output logic [num_regions-1:0][addr_w-1:0] region_base,
  output logic [num_regions-1:0][addr_w-1:0] region_limit,
  output logic [num_regions-1:0][perm_w-1:0] region_perm
);

  // region table
  // reset leaves every region at 0..0 with no permission
  // so all accesses fault until software sets them up
  always_ff @(posedge clk) begin
    if (reset) begin
      region_base  <= '0;
      region_limit <= '0;
      region_perm  <= '0;
    end else if (cfg_we) begin
      // one region per write, visible from the next cycle
      region_base[cfg_sel]  <= cfg_base;
      region_limit[cfg_sel] <= cfg_limit;
      region_perm[cfg_sel]  <= cfg_perm;
    end
  end

  // limit is inclusive
  // a limit under the base would make an empty region that never hits
  assert property (@(posedge clk) disable iff (reset) cfg_we |-> (cfg_limit >= cfg_base))
    else $error("mmu_region_cfg: region %0d written with limit below base", cfg_sel);

endmodule

/* source/mem_array.sv */
`timescale 1ns/1ps

module mem_array
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              head_valid,
  input  logic [1:0]        head_kind,
  input  logic [1:0]        head_size,
  input  logic [addr_w-1:0] head_addr,
  input  logic [data_w-1:0] head_wdata,
  input  logic              access_ok,
  output logic              rsp_valid,
  output logic              rsp_fault,
  output logic [data_w-1:0] rsp_rdata
);

  mem_word_u mem [mem_words];

  // upper address bits beyond the depth are dropped
  logic [$clog2(mem_words)-1:0] word_idx;
  logic [1:0]                   byte_off;
  logic [data_w/8-1:0]          keep_mask;
  logic [data_w/8-1:0]          lane_mask;
  mem_word_u                    wdata_in;
  mem_word_u                    wdata_lane;
  mem_word_u                    cur_word;
  mem_word_u                    rd_word;
  logic                         do_write;
  logic                         do_read;

  assign word_idx      = head_addr[2 +: $clog2(mem_words)];
  assign byte_off      = head_addr[1:0];
  assign wdata_in.word = head_wdata;
  assign cur_word      = mem[word_idx];

  // lanes kept in the right-justified result
  always_comb begin
    case (head_size)
      size_byte: keep_mask = 4'b0001;
      size_half: keep_mask = 4'b0011;
      size_word: keep_mask = 4'b1111;
      default:   keep_mask = 4'b0000;
    endcase
  end

  // same lanes moved up to where the address puts them
  assign lane_mask = keep_mask << byte_off;

  assign do_write = head_valid && access_ok && (head_kind == kind_write);
  assign do_read  = head_valid && access_ok && (head_kind != kind_write);

  // steer write bytes onto their lanes and pull read bytes down to lane 0
  always_comb begin
    for (int i = 0; i < data_w / 8; i++) begin
      wdata_lane.bytes[i] = wdata_in.bytes[2'(i) - byte_off];
      rd_word.bytes[i]    = keep_mask[i] ? cur_word.bytes[2'(i) + byte_off] : 8'h00;
    end
  end

  // byte-lane merge, untouched lanes keep their old bytes
  always_ff @(posedge clk) begin
    if (do_write) begin
      for (int i = 0; i < data_w / 8; i++) begin
        if (lane_mask[i]) begin
          mem[word_idx].bytes[i] <= wdata_lane.bytes[i];
        end
      end
    end
  end

  // response flags, one per popped request
  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
      rsp_fault <= 1'b0;
    end else begin
      rsp_valid <= head_valid;
      rsp_fault <= head_valid && !access_ok;
    end
  end

  // writes and faulted reads come back as zero
  always_ff @(posedge clk) begin
    rsp_rdata <= do_read ? rd_word.word : '0;
  end

endmodule

/* source/mem_top.sv */
`timescale 1ns/1ps

module mem_top
  import mem_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  // request port from the cpu
  input  logic                    req_valid,
  input  logic [1:0]              req_kind,
  input  logic [1:0]              req_size,
  input  logic [addr_w-1:0]       req_addr,
  input  logic [data_w-1:0]       req_wdata,
  output logic                    credit_return,
  // response port back to the cpu
  output logic                    rsp_valid,
  output logic                    rsp_fault,
  output logic [data_w-1:0]       rsp_rdata,
  // region configuration port
  input  logic                    cfg_we,
  input  logic [region_idx_w-1:0] cfg_sel,
  input  logic [addr_w-1:0]       cfg_base,
  input  logic [addr_w-1:0]       cfg_limit,
  input  logic [perm_w-1:0]       cfg_perm
);

  // head of the request buffer
  logic              head_valid;
  logic [1:0]        head_kind;
  logic [1:0]        head_size;
  logic [addr_w-1:0] head_addr;
  logic [data_w-1:0] head_wdata;

  // region registers feeding the checker
  logic [num_regions-1:0][addr_w-1:0] region_base;
  logic [num_regions-1:0][addr_w-1:0] region_limit;
  logic [num_regions-1:0][perm_w-1:0] region_perm;

  // legality of the current head
  logic access_ok;

  // buffers requests, one credit back per pop
  req_credit_queue u_queue (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_size      (req_size),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .head_valid    (head_valid),
    .head_kind     (head_kind),
    .head_size     (head_size),
    .head_addr     (head_addr),
    .head_wdata    (head_wdata),
    .credit_return (credit_return)
  );

  mmu_region_cfg u_region_cfg (
    .clk          (clk),
    .reset        (reset),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_base     (cfg_base),
    .cfg_limit    (cfg_limit),
    .cfg_perm     (cfg_perm),
    .region_base  (region_base),
    .region_limit (region_limit),
    .region_perm  (region_perm)
  );

  // combinational check on the head item
  mmu_access_check u_access_check (
    .head_valid   (head_valid),
    .head_kind    (head_kind),
    .head_size    (head_size),
    .head_addr    (head_addr),
    .region_base  (region_base),
    .region_limit (region_limit),
    .region_perm  (region_perm),
    .access_ok    (access_ok)
  );

  // storage access and response register
  mem_array u_array (
    .clk        (clk),
    .reset      (reset),
    .head_valid (head_valid),
    .head_kind  (head_kind),
    .head_size  (head_size),
    .head_addr  (head_addr),
    .head_wdata (head_wdata),
    .access_ok  (access_ok),
    .rsp_valid  (rsp_valid),
    .rsp_fault  (rsp_fault),
    .rsp_rdata  (rsp_rdata)
  );

endmodule

/* source/req_credit_queue.sv */
`timescale 1ns/1ps

module req_credit_queue
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  input  logic [1:0]        req_kind,
  input  logic [1:0]        req_size,
  input  logic [addr_w-1:0] req_addr,
  input  logic [data_w-1:0] req_wdata,
  output logic              head_valid,
  output logic [1:0]        head_kind,
  output logic [1:0]        head_size,
  output logic [addr_w-1:0] head_addr,
  output logic [data_w-1:0] head_wdata,
  output logic              credit_return
);

  // slot storage
  logic [1:0]        kind_q  [queue_depth];
  logic [1:0]        size_q  [queue_depth];
  logic [addr_w-1:0] addr_q  [queue_depth];
  logic [data_w-1:0] wdata_q [queue_depth];

  // depth is a power of two so pointers wrap on their own
  logic [$clog2(queue_depth)-1:0] wr_ptr;
  logic [$clog2(queue_depth)-1:0] rd_ptr;
  logic [$clog2(queue_depth):0]   count;
  logic                           full;

  // nothing downstream stalls, so a non-empty head leaves this cycle
  assign head_valid    = (count != '0);
  assign credit_return = head_valid;
  assign full          = (count == queue_depth);

  assign head_kind  = kind_q[rd_ptr];
  assign head_size  = size_q[rd_ptr];
  assign head_addr  = addr_q[rd_ptr];
  assign head_wdata = wdata_q[rd_ptr];

  // payload write at the tail
  always_ff @(posedge clk) begin
    if (req_valid) begin
      kind_q[wr_ptr]  <= req_kind;
      size_q[wr_ptr]  <= req_size;
      addr_q[wr_ptr]  <= req_addr;
      wdata_q[wr_ptr] <= req_wdata;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (head_valid) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count as is
      case ({req_valid, head_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // cpu pushed with no credit in hand
  assert property (@(posedge clk) disable iff (reset) req_valid |-> !full)
    else $error("req_credit_queue: request arrived while all slots were taken");

endmodule

/* verif/mem_tb_table.svh */
// columns: op, kind, size, addr, wdata, expected rdata, expected fault
// op 1 is a region write: kind bit 0 = region, addr = base, wdata = limit, rdata = perm
localparam int tbl_len = 34;
localparam logic [101:0] test_table [tbl_len] = '{
  // nothing configured yet, so everything faults
  {1'b0, kind_data,  size_word, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1'b1},
  {1'b0, kind_write, size_word, 32'h0000_0004, 32'hdead_beef, 32'h0000_0000, 1'b1},
  {1'b0, kind_instr, size_word, 32'h0000_0200, 32'h0000_0000, 32'h0000_0000, 1'b1},
  // region 0 read+write, region 1 read+execute
  {1'b1, 2'd0,       2'd0,      32'h0000_0000, 32'h0000_01ff, 32'h0000_0003, 1'b0},
  {1'b1, 2'd1,       2'd0,      32'h0000_0200, 32'h0000_03ff, 32'h0000_0005, 1'b0},
  {1'b0, kind_write, size_word, 32'h0000_0010, 32'h1122_3344, 32'h0000_0000, 1'b0},
  {1'b0, kind_write, size_word, 32'h0000_0014, 32'ha5a5_5a5a, 32'h0000_0000, 1'b0},
  {1'b0, kind_data,  size_word, 32'h0000_0010, 32'h0000_0000, 32'h1122_3344, 1'b0},
  {1'b0, kind_data,  size_word, 32'h0000_0014, 32'h0000_0000, 32'ha5a5_5a5a, 1'b0},
  // sub-word lane merge and extraction
  {1'b0, kind_write, size_word, 32'h0000_0020, 32'h0102_0304, 32'h0000_0000, 1'b0},
  {1'b0, kind_write, size_byte, 32'h0000_0021, 32'hffff_ffab, 32'h0000_0000, 1'b0},
  {1'b0, kind_write, size_half, 32'h0000_0022, 32'h0000_cdef, 32'h0000_0000, 1'b0},
  {1'b0, kind_data,  size_word, 32'h0000_0020, 32'h0000_0000, 32'hcdef_ab04, 1'b0},
  {1'b0, kind_data,  size_byte, 32'h0000_0023, 32'h0000_0000, 32'h0000_00cd, 1'b0},
  {1'b0, kind_data,  size_half, 32'h0000_0022, 32'h0000_0000, 32'h0000_cdef, 1'b0},
  {1'b0, kind_data,  size_half, 32'h0000_0020, 32'h0000_0000, 32'h0000_ab04, 1'b0},
  // no execute in region 0, misaligned, past 0x3ff, then re-read
  {1'b0, kind_instr, size_word, 32'h0000_0010, 32'h0000_0000, 32'h0000_0000, 1'b1},
  {1'b0, kind_write, size_half, 32'h0000_0011, 32'h0000_ffff, 32'h0000_0000, 1'b1},
  {1'b0, kind_data,  size_word, 32'h0000_0012, 32'h0000_0000, 32'h0000_0000, 1'b1},
  {1'b0, kind_data,  size_word, 32'h0000_0400, 32'h0000_0000, 32'h0000_0000, 1'b1},
  {1'b0, kind_data,  size_word, 32'h0000_0010, 32'h0000_0000, 32'h1122_3344, 1'b0},
  // preload region 1 while it is writable, then back to read+execute
  {1'b1, 2'd1,       2'd0,      32'h0000_0200, 32'h0000_03ff, 32'h0000_0007, 1'b0},
  {1'b0, kind_write, size_word, 32'h0000_0200, 32'h0000_0013, 32'h0000_0000, 1'b0},
  {1'b0, kind_write, size_word, 32'h0000_0204, 32'h1234_5678, 32'h0000_0000, 1'b0},
  {1'b1, 2'd1,       2'd0,      32'h0000_0200, 32'h0000_03ff, 32'h0000_0005, 1'b0},
  {1'b0, kind_instr, size_word, 32'h0000_0200, 32'h0000_0000, 32'h0000_0013, 1'b0},
  {1'b0, kind_instr, size_half, 32'h0000_0206, 32'h0000_0000, 32'h0000_1234, 1'b0},
  {1'b0, kind_write, size_word, 32'h0000_0204, 32'hffff_ffff, 32'h0000_0000, 1'b1},
  {1'b0, kind_instr, size_word, 32'h0000_0204, 32'h0000_0000, 32'h1234_5678, 1'b0},
  {1'b0, kind_data,  size_byte, 32'h0000_0205, 32'h0000_0000, 32'h0000_0056, 1'b0},
  // burst of queue_depth reads, order shows in the data
  {1'b0, kind_data,  size_word, 32'h0000_0010, 32'h0000_0000, 32'h1122_3344, 1'b0},
  {1'b0, kind_data,  size_word, 32'h0000_0014, 32'h0000_0000, 32'ha5a5_5a5a, 1'b0},
  {1'b0, kind_data,  size_word, 32'h0000_0020, 32'h0000_0000, 32'hcdef_ab04, 1'b0},
  {1'b0, kind_instr, size_word, 32'h0000_0200, 32'h0000_0000, 32'h0000_0013, 1'b0}
};

/* verif/mem_tb.sv */
`timescale 1ns/1ps

module mem_tb
  import mem_pkg::*;
();

  `include "mem_tb_table.svh"

  localparam int fill_count   = 128;
  localparam int random_count = 200;
  // worst case per request plus slack in ns
  localparam int watchdog_ns  =
    (tbl_len + fill_count + random_count) * (queue_depth + 4) * 8 + 2000;

  logic                    clk;
  logic                    reset;
  logic                    req_valid;
  logic [1:0]              req_kind;
  logic [1:0]              req_size;
  logic [addr_w-1:0]       req_addr;
  logic [data_w-1:0]       req_wdata;
  logic                    credit_return;
  logic                    rsp_valid;
  logic                    rsp_fault;
  logic [data_w-1:0]       rsp_rdata;
  logic                    cfg_we;
  logic [region_idx_w-1:0] cfg_sel;
  logic [addr_w-1:0]       cfg_base;
  logic [addr_w-1:0]       cfg_limit;
  logic [perm_w-1:0]       cfg_perm;

  // cpu side bookkeeping
  int credits;
  int pending_credit;
  int issued;
  int returned;
  int seed;
  mem_word_u exp_rdata_q[$];
  logic      exp_fault_q[$];

  // byte model and a copy of the region setup
  logic [7:0]        model [1024];
  logic [addr_w-1:0] tb_base [num_regions];
  logic [addr_w-1:0] tb_limit [num_regions];
  logic [perm_w-1:0] tb_perm [num_regions];

  // one table row unpacked
  logic        t_op;
  logic [1:0]  t_kind;
  logic [1:0]  t_size;
  logic [31:0] t_addr;
  logic [31:0] t_wdata;
  logic [31:0] t_exp;
  logic        t_fault;
  mem_word_u   t_word;
  logic [31:0] r;
  logic [31:0] rand_addr;

  mem_top uut (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_kind      (req_kind),
    .req_size      (req_size),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .credit_return (credit_return),
    .rsp_valid     (rsp_valid),
    .rsp_fault     (rsp_fault),
    .rsp_rdata     (rsp_rdata),
    .cfg_we        (cfg_we),
    .cfg_sel       (cfg_sel),
    .cfg_base      (cfg_base),
    .cfg_limit     (cfg_limit),
    .cfg_perm      (cfg_perm)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "mem_tb stopped at the first error");
  endtask

  task automatic check_rdata(input mem_word_u got, input mem_word_u exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: rsp_rdata %h, expected %h", $time, got.word, exp.word);
      abort_run();
    end
  endtask

  task automatic check_fault(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: rsp_fault %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // oldest expectation goes with each response
  task automatic take_response();
    mem_word_u got;
    if (exp_rdata_q.size() == 0) begin
      $display("a response came at %0d ns with no request outstanding", $time);
      abort_run();
    end else begin
      got.word = rsp_rdata;
      check_fault(rsp_fault, exp_fault_q.pop_front());
      check_rdata(got, exp_rdata_q.pop_front());
    end
  endtask

  // one falling edge
  // a credit seen now frees its slot at the next rising edge, so it is usable one cycle later
  task automatic step_cycle();
    @(negedge clk);
    req_valid = 1'b0;
    cfg_we    = 1'b0;
    credits        = credits + pending_credit;
    pending_credit = credit_return ? 1 : 0;
    returned       = returned + pending_credit;
    if (credits > queue_depth) begin
      $display("credit count rose above %0d at %0d ns", queue_depth, $time);
      abort_run();
    end
    if (rsp_valid) begin
      take_response();
    end
  endtask

  task automatic issue_req(input logic [1:0] kind, input logic [1:0] size,
                           input logic [31:0] addr, input logic [31:0] wdata,
                           input mem_word_u exp_rdata, input logic exp_fault);
    step_cycle();
    while (credits == 0) begin
      step_cycle();
    end
    req_valid = 1'b1;
    req_kind  = kind;
    req_size  = size;
    req_addr  = addr;
    req_wdata = wdata;
    credits   = credits - 1;
    issued    = issued + 1;
    exp_rdata_q.push_back(exp_rdata);
    exp_fault_q.push_back(exp_fault);
  endtask

  task automatic drain();
    while (exp_rdata_q.size() != 0) begin
      step_cycle();
    end
  endtask

  // region writes only with nothing in flight
  task automatic write_region(input logic [region_idx_w-1:0] sel, input logic [31:0] base,
                              input logic [31:0] limit, input logic [perm_w-1:0] perm);
    drain();
    step_cycle();
    cfg_we        = 1'b1;
    cfg_sel       = sel;
    cfg_base      = base;
    cfg_limit     = limit;
    cfg_perm      = perm;
    tb_base[sel]  = base;
    tb_limit[sel] = limit;
    tb_perm[sel]  = perm;
  endtask

  // alignment, containment in the first hit region, then the kind's permission
  function automatic logic faults(input logic [1:0] kind, input logic [1:0] size,
                                  input logic [31:0] addr);
    int                n;
    logic              hit;
    logic [perm_w-1:0] p;
    logic [32:0]       last;
    if (kind == 2'd3 || size == 2'd3) begin
      return 1'b1;
    end
    n = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
    if (addr % n != 0) begin
      return 1'b1;
    end
    last = {1'b0, addr} + 33'(n) - 33'd1;
    hit  = 1'b0;
    p    = '0;
    for (int i = 0; i < num_regions; i++) begin
      if (!hit && addr >= tb_base[i] && last <= {1'b0, tb_limit[i]}) begin
        hit = 1'b1;
        p   = tb_perm[i];
      end
    end
    if (!hit) begin
      return 1'b1;
    end
    case (kind)
      kind_instr: return !p[2];
      kind_data:  return !p[0];
      default:    return !p[1];
    endcase
  endfunction

  // mixes every address bit in
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return (a * 32'h9e37_79b9) ^ {a[15:0], ~a[15:0]};
  endfunction

  // expected result from the byte model
  // model updated on good writes
  task automatic model_access(input logic [1:0] kind, input logic [1:0] size,
                              input logic [31:0] addr, input logic [31:0] wdata);
    int        n;
    logic      f;
    mem_word_u exp;
    n        = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
    f        = faults(kind, size, addr);
    exp.word = '0;
    if (!f) begin
      for (int i = 0; i < n; i++) begin
        if (kind == kind_write) begin
          model[int'(addr[9:0]) + i] = wdata[8*i +: 8];
        end else begin
          exp.bytes[i] = model[int'(addr[9:0]) + i];
        end
      end
    end
    issue_req(kind, size, addr, wdata, exp, f);
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout at %0d ns: responses stopped arriving", $time);
    abort_run();
  end

  initial begin
    seed           = 77440;
    reset          = 1'b1;
    req_valid      = 1'b0;
    req_kind       = 2'd0;
    req_size       = 2'd0;
    req_addr       = '0;
    req_wdata      = '0;
    cfg_we         = 1'b0;
    cfg_sel        = '0;
    cfg_base       = '0;
    cfg_limit      = '0;
    cfg_perm       = '0;
    credits        = queue_depth;
    pending_credit = 0;
    issued         = 0;
    returned       = 0;
    for (int i = 0; i < num_regions; i++) begin
      tb_base[i]  = '0;
      tb_limit[i] = '0;
      tb_perm[i]  = '0;
    end
    repeat (8) @(negedge clk);
    reset = 1'b0;
    // outputs quiet straight out of reset
    if (rsp_valid !== 1'b0 || credit_return !== 1'b0) begin
      $display("rsp_valid or credit_return was not low after reset");
      abort_run();
    end

    for (int t = 0; t < tbl_len; t++) begin
      {t_op, t_kind, t_size, t_addr, t_wdata, t_exp, t_fault} = test_table[t];
      if (t_op) begin
        write_region(t_kind[0], t_addr, t_wdata, t_exp[perm_w-1:0]);
      end else begin
        t_word.word = t_exp;
        issue_req(t_kind, t_size, t_addr, t_wdata, t_word, t_fault);
      end
    end
    drain();

    // known contents for all of region 0
    for (int a = 0; a < fill_count * 4; a += 4) begin
      model_access(kind_write, size_word, 32'(a), fill_word(32'(a)));
    end

    // legal kinds and sizes only
    // faults come from alignment, execute and range
    repeat (random_count) begin
      r         = $random(seed);
      rand_addr = {23'd0, r[8:0]};
      if (r[17:16] == 2'b11) begin
        rand_addr = rand_addr | 32'h0000_0800;
      end
      model_access((r[1:0] == 2'd3) ? kind_data : r[1:0],
                   (r[3:2] == 2'd3) ? size_word : r[3:2],
                   rand_addr, $random(seed));
    end
    drain();

    if (returned != issued || credits != queue_depth) begin
      $display("%0d credit_return pulses for %0d requests, %0d credits held",
               returned, issued, credits);
      abort_run();
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule
